/* db_router_config.svh */
// Sizing macros for the key/value query router
// Key and value widths, bank count and open-query depth

`ifndef DB_ROUTER_CONFIG_SVH
`define DB_ROUTER_CONFIG_SVH

// ==================================================
// Bus widths
// ==================================================
`define DB_KEY_WIDTH   8
`define DB_VALUE_WIDTH 32

// ==================================================
// Router sizing
// ==================================================
// Lookup banks served in round-robin order
`define DB_NUM_BANKS   2
// Largest number of queries in flight
`define DB_CTXT_DEPTH  8

`endif

/* db_router_pkg.sv */
// Shared types for the key/value query router

`include "db_router_config.svh"

package db_router_pkg;

    // Requester count and indices
    localparam int NUM_SRC = 2;

    typedef logic [0:0] src_sel_t;

    localparam src_sel_t SRC_HI = 1'b0;
    localparam src_sel_t SRC_LO = 1'b1;

    // Bus payloads
    typedef logic [`DB_KEY_WIDTH-1:0]   key_t;
    typedef logic [`DB_VALUE_WIDTH-1:0] value_t;

    // Bank index
    typedef logic [$clog2(`DB_NUM_BANKS)-1:0] bank_sel_t;

    // Context of one open query, kept until its ack returns
    typedef struct packed {
        src_sel_t  src;
        bank_sel_t bank;
    } ctxt_t;

endpackage : db_router_pkg

/* db_query_if.sv */
// Query bus between a lookup requester and a responder
// Request is req/key with rdy back; response is ack with error/valid/value

interface db_query_if
    import db_router_pkg::*;
();

    // Request side
    logic   req;
    key_t   key;
    logic   rdy;

    // Response side, meaningful only while ack is high
    logic   ack;
    logic   error;
    logic   valid;
    value_t value;

    modport requester (
        output req,
        output key,
        input  rdy,
        input  ack,
        input  error,
        input  valid,
        input  value
    );

    modport responder (
        input  req,
        input  key,
        output rdy,
        output ack,
        output error,
        output valid,
        output value
    );

endinterface : db_query_if

/* db_ctxt_fifo.sv */
// Context FIFO for open queries
// Circular buffer, one-cycle write, head visible combinationally

`include "db_router_config.svh"

module db_ctxt_fifo
    import db_router_pkg::*;
#(
    parameter int DEPTH = `DB_CTXT_DEPTH
) (
    input  logic  clk,
    input  logic  i_reset,
    input  logic  i_wr,
    input  ctxt_t i_wr_data,
    input  logic  i_rd,
    output ctxt_t o_rd_data,
    output logic  o_full,
    output logic  o_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);

    ctxt_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    // Overflow and underflow requests are dropped
    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    assign o_full    = (count == (AW + 1)'(DEPTH));
    assign o_empty   = (count == '0);
    assign o_rd_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : db_ctxt_fifo

/* db_route_ctrl.sv */
// Router control: strict-priority grant, round-robin bank pointer,
// context push/pop and back-pressure

`include "db_router_config.svh"

module db_route_ctrl
    import db_router_pkg::*;
(
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_hi_req,
    input  logic      i_lo_req,
    input  logic      i_bank_rdy [`DB_NUM_BANKS],
    input  logic      i_bank_ack [`DB_NUM_BANKS],
    input  logic      i_fifo_full,
    input  logic      i_fifo_empty,
    output src_sel_t  o_grant,
    output bank_sel_t o_bank_sel,
    output logic      o_accept_ok,
    output logic      o_push,
    output logic      o_pop
);

    // Bank that takes the next accepted query
    bank_sel_t wr_bank;
    // Bank of the oldest open query, same as the FIFO head's bank
    bank_sel_t rd_bank;
    logic      any_req;

    function automatic bank_sel_t next_bank(input bank_sel_t cur);
        if (cur == bank_sel_t'(`DB_NUM_BANKS - 1)) begin
            return '0;
        end
        return bank_sel_t'(cur + 1'b1);
    endfunction

    // ==================================================
    // Grant and acceptance
    // ==================================================
    assign any_req = i_hi_req || i_lo_req;

    // High priority wins whenever it asks
    assign o_grant    = i_hi_req ? SRC_HI : SRC_LO;
    assign o_bank_sel = wr_bank;

    // Selected bank must be ready and there must be room for the context
    assign o_accept_ok = any_req && i_bank_rdy[wr_bank] && !i_fifo_full;
    assign o_push      = o_accept_ok;

    // Responses come back in order, so only the head bank's ack retires
    assign o_pop = i_bank_ack[rd_bank] && !i_fifo_empty;

    // ==================================================
    // Round-robin pointers
    // ==================================================
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_bank <= '0;
            rd_bank <= '0;
        end else begin
            if (o_push) begin
                wr_bank <= next_bank(wr_bank);
            end
            if (o_pop) begin
                rd_bank <= next_bank(rd_bank);
            end
        end
    end

endmodule : db_route_ctrl

/* db_request_mux.sv */
// Request mux: forwards the granted requester's query
// and returns rdy to that requester only

module db_request_mux
    import db_router_pkg::*;
(
    input  src_sel_t      i_grant,
    input  logic          i_accept_ok,
    db_query_if.responder src_hi,
    db_query_if.responder src_lo,
    db_query_if.requester mux_out
);

    logic hi_sel;
    logic accept;

    assign hi_sel = (i_grant == SRC_HI);

    // Granted request toward the bank steering
    assign mux_out.req = hi_sel ? src_hi.req : src_lo.req;
    assign mux_out.key = hi_sel ? src_hi.key : src_lo.key;

    // Accept qualified by the bank side as well
    assign accept = i_accept_ok && mux_out.rdy;

    // Non-granted requester never sees rdy
    assign src_hi.rdy = hi_sel && accept;
    assign src_lo.rdy = !hi_sel && accept;

endmodule : db_request_mux

/* db_bank_steer.sv */
// Bank steering: sends each query to the selected bank and routes
// the head bank's response back to the owning requester

`include "db_router_config.svh"

module db_bank_steer
    import db_router_pkg::*;
(
    input  bank_sel_t     i_bank_sel,
    input  ctxt_t         i_head,
    input  logic          i_head_valid,
    db_query_if.responder mux_in,
    db_query_if.requester bank [`DB_NUM_BANKS],
    db_query_if.responder src_rsp [NUM_SRC]
);

    // Bank responses flattened for indexed selection
    logic   bank_rdy   [`DB_NUM_BANKS];
    logic   bank_ack   [`DB_NUM_BANKS];
    logic   bank_error [`DB_NUM_BANKS];
    logic   bank_valid [`DB_NUM_BANKS];
    value_t bank_value [`DB_NUM_BANKS];

    // ==================================================
    // Request fan-out
    // ==================================================
    for (genvar g = 0; g < `DB_NUM_BANKS; g++) begin : g_bank
        // req only to the selected bank, key to all
        assign bank[g].req = mux_in.req && (i_bank_sel == bank_sel_t'(g));
        assign bank[g].key = mux_in.key;

        assign bank_rdy[g]   = bank[g].rdy;
        assign bank_ack[g]   = bank[g].ack;
        assign bank_error[g] = bank[g].error;
        assign bank_valid[g] = bank[g].valid;
        assign bank_value[g] = bank[g].value;
    end

    assign mux_in.rdy = bank_rdy[i_bank_sel];

    // ==================================================
    // Response selection
    // ==================================================
    // Only the bank named in the FIFO head may answer
    assign mux_in.ack   = i_head_valid && bank_ack[i_head.bank];
    assign mux_in.error = bank_error[i_head.bank];
    assign mux_in.valid = bank_valid[i_head.bank];
    assign mux_in.value = bank_value[i_head.bank];

    for (genvar s = 0; s < NUM_SRC; s++) begin : g_src
        logic owner;

        assign owner = (i_head.src == src_sel_t'(s));

        assign src_rsp[s].ack   = owner && mux_in.ack;
        assign src_rsp[s].error = owner && mux_in.ack && mux_in.error;
        assign src_rsp[s].valid = owner && mux_in.ack && mux_in.valid;
        // value is qualified by ack alone
        assign src_rsp[s].value = mux_in.value;
    end

endmodule : db_bank_steer

/* db_query_router.sv */
// Key/value query router: two priority requesters onto round-robin banks,
// with in-order context tracking for the responses

`include "db_router_config.svh"

module db_query_router
    import db_router_pkg::*;
(
    input  logic   clk,
    input  logic   i_reset,

    // High-priority requester
    input  logic   i_hi_req,
    input  key_t   i_hi_key,
    output logic   o_hi_rdy,
    output logic   o_hi_ack,
    output logic   o_hi_error,
    output logic   o_hi_valid,
    output value_t o_hi_value,

    // Low-priority requester
    input  logic   i_lo_req,
    input  key_t   i_lo_key,
    output logic   o_lo_rdy,
    output logic   o_lo_ack,
    output logic   o_lo_error,
    output logic   o_lo_valid,
    output value_t o_lo_value,

    // Lookup banks
    output logic   o_bank_req   [`DB_NUM_BANKS],
    output key_t   o_bank_key   [`DB_NUM_BANKS],
    input  logic   i_bank_rdy   [`DB_NUM_BANKS],
    input  logic   i_bank_ack   [`DB_NUM_BANKS],
    input  logic   i_bank_error [`DB_NUM_BANKS],
    input  logic   i_bank_valid [`DB_NUM_BANKS],
    input  value_t i_bank_value [`DB_NUM_BANKS]
);

    src_sel_t  grant;
    bank_sel_t bank_sel;
    logic      accept_ok;
    logic      push;
    logic      pop;
    logic      fifo_full;
    logic      fifo_empty;
    ctxt_t     push_ctxt;
    ctxt_t     head;

    db_query_if src_if [NUM_SRC] ();
    db_query_if mux_if ();
    db_query_if bank_if [`DB_NUM_BANKS] ();

    // ==================================================
    // Port mapping
    // ==================================================
    assign src_if[SRC_HI].req = i_hi_req;
    assign src_if[SRC_HI].key = i_hi_key;
    assign o_hi_rdy   = src_if[SRC_HI].rdy;
    assign o_hi_ack   = src_if[SRC_HI].ack;
    assign o_hi_error = src_if[SRC_HI].error;
    assign o_hi_valid = src_if[SRC_HI].valid;
    assign o_hi_value = src_if[SRC_HI].value;

    assign src_if[SRC_LO].req = i_lo_req;
    assign src_if[SRC_LO].key = i_lo_key;
    assign o_lo_rdy   = src_if[SRC_LO].rdy;
    assign o_lo_ack   = src_if[SRC_LO].ack;
    assign o_lo_error = src_if[SRC_LO].error;
    assign o_lo_valid = src_if[SRC_LO].valid;
    assign o_lo_value = src_if[SRC_LO].value;

    for (genvar g = 0; g < `DB_NUM_BANKS; g++) begin : g_bank_port
        assign o_bank_req[g]     = bank_if[g].req;
        assign o_bank_key[g]     = bank_if[g].key;
        assign bank_if[g].rdy    = i_bank_rdy[g];
        assign bank_if[g].ack    = i_bank_ack[g];
        assign bank_if[g].error  = i_bank_error[g];
        assign bank_if[g].valid  = i_bank_valid[g];
        assign bank_if[g].value  = i_bank_value[g];
    end

    // ==================================================
    // Blocks
    // ==================================================
    db_route_ctrl u_ctrl (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_hi_req     (i_hi_req),
        .i_lo_req     (i_lo_req),
        .i_bank_rdy   (i_bank_rdy),
        .i_bank_ack   (i_bank_ack),
        .i_fifo_full  (fifo_full),
        .i_fifo_empty (fifo_empty),
        .o_grant      (grant),
        .o_bank_sel   (bank_sel),
        .o_accept_ok  (accept_ok),
        .o_push       (push),
        .o_pop        (pop)
    );

    db_request_mux u_mux (
        .i_grant     (grant),
        .i_accept_ok (accept_ok),
        .src_hi      (src_if[SRC_HI]),
        .src_lo      (src_if[SRC_LO]),
        .mux_out     (mux_if)
    );

    db_bank_steer u_steer (
        .i_bank_sel   (bank_sel),
        .i_head       (head),
        .i_head_valid (!fifo_empty),
        .mux_in       (mux_if),
        .bank         (bank_if),
        .src_rsp      (src_if)
    );

    // Source and bank of each accepted query
    assign push_ctxt = '{src: grant, bank: bank_sel};

    db_ctxt_fifo u_fifo (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_wr      (push),
        .i_wr_data (push_ctxt),
        .i_rd      (pop),
        .o_rd_data (head),
        .o_full    (fifo_full),
        .o_empty   (fifo_empty)
    );

endmodule : db_query_router

/* tb_db_query_router.sv */
// Testbench for the key/value query router
// Bank models, in-order scoreboard and assertions on routing and back-pressure

`include "db_router_config.svh"

module tb_db_query_router;
    import db_router_pkg::*;

    localparam int NB          = `DB_NUM_BANKS;
    localparam int ACK_LATENCY = 3;
    // Traffic below takes about 200 cycles
    localparam int MAX_CYCLES  = 2000;

    typedef struct packed {
        bit   src;
        key_t key;
        int   bank;
    } query_t;

    typedef struct packed {
        int   bank;
        key_t key;
        int   acc_cyc;
    } pending_t;

    logic   clk;
    logic   i_reset;
    logic   i_hi_req;
    key_t   i_hi_key;
    logic   o_hi_rdy;
    logic   o_hi_ack;
    logic   o_hi_error;
    logic   o_hi_valid;
    value_t o_hi_value;
    logic   i_lo_req;
    key_t   i_lo_key;
    logic   o_lo_rdy;
    logic   o_lo_ack;
    logic   o_lo_error;
    logic   o_lo_valid;
    value_t o_lo_value;
    logic   o_bank_req   [NB];
    key_t   o_bank_key   [NB];
    logic   i_bank_rdy   [NB];
    logic   i_bank_ack   [NB];
    logic   i_bank_error [NB];
    logic   i_bank_valid [NB];
    value_t i_bank_value [NB];

    query_t   sb [$];
    pending_t pend [$];
    int       open_cnt = 0;
    int       exp_bank = 0;
    int       stall_bank;
    int       errors = 0;
    int       checks = 0;
    int       cyc = 0;
    int       bank_cyc = 0;
    logic     hold_ack;
    logic     ack_out = 1'b0;

    db_query_router UUT (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_hi_req     (i_hi_req),
        .i_hi_key     (i_hi_key),
        .o_hi_rdy     (o_hi_rdy),
        .o_hi_ack     (o_hi_ack),
        .o_hi_error   (o_hi_error),
        .o_hi_valid   (o_hi_valid),
        .o_hi_value   (o_hi_value),
        .i_lo_req     (i_lo_req),
        .i_lo_key     (i_lo_key),
        .o_lo_rdy     (o_lo_rdy),
        .o_lo_ack     (o_lo_ack),
        .o_lo_error   (o_lo_error),
        .o_lo_valid   (o_lo_valid),
        .o_lo_value   (o_lo_value),
        .o_bank_req   (o_bank_req),
        .o_bank_key   (o_bank_key),
        .i_bank_rdy   (i_bank_rdy),
        .i_bank_ack   (i_bank_ack),
        .i_bank_error (i_bank_error),
        .i_bank_valid (i_bank_valid),
        .i_bank_value (i_bank_value)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Lookup result of a bank for a given key
    function automatic value_t model_value(input key_t key, input int bank);
        return value_t'(key) * 3 + value_t'(bank) * 1000;
    endfunction

    task automatic check_value(input string name, input value_t exp, input value_t act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("Fail %0t: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // ==================================================
    // Bank models
    // ==================================================
    task automatic drive_bank_response();
        pending_t p;
        for (int b = 0; b < NB; b++) begin
            i_bank_ack[b]   = 1'b0;
            i_bank_error[b] = 1'b0;
            i_bank_valid[b] = 1'b0;
            i_bank_value[b] = '0;
        end
        ack_out = 1'b0;
        // Ack is sampled on the edge after it is driven
        if (pend.size() > 0 && !hold_ack) begin
            p = pend[0];
            if (bank_cyc - p.acc_cyc >= ACK_LATENCY - 1) begin
                i_bank_ack[p.bank]   = 1'b1;
                i_bank_value[p.bank] = model_value(p.key, p.bank);
                i_bank_valid[p.bank] = !p.key[0];
                i_bank_error[p.bank] = (p.key == 8'd255);
                ack_out = 1'b1;
            end
        end
    endtask

    // Both banks share one queue since equal latency keeps the global order
    always @(posedge clk) begin
        bank_cyc++;
        if (i_reset) begin
            pend.delete();
        end else begin
            if (ack_out) begin
                void'(pend.pop_front());
            end
            // Handshake completes only when the router passes rdy to a requester
            for (int b = 0; b < NB; b++) begin
                if (o_bank_req[b] && i_bank_rdy[b] && (o_hi_rdy || o_lo_rdy)) begin
                    pend.push_back('{bank: b, key: o_bank_key[b], acc_cyc: bank_cyc});
                end
            end
        end
        #1;
        drive_bank_response();
    end

    // ==================================================
    // Scoreboard
    // ==================================================
    task automatic check_ack(input query_t q);
        string  pfx;
        string  other;
        pfx   = q.src ? "o_lo" : "o_hi";
        other = q.src ? "o_hi" : "o_lo";
        check_value({pfx, "_ack"}, 1, q.src ? o_lo_ack : o_hi_ack);
        check_value({other, "_ack"}, 0, q.src ? o_hi_ack : o_lo_ack);
        check_value({pfx, "_value"}, model_value(q.key, q.bank),
                    q.src ? o_lo_value : o_hi_value);
        check_value({pfx, "_valid"}, !q.key[0], q.src ? o_lo_valid : o_hi_valid);
        check_value({pfx, "_error"}, q.key == 8'd255, q.src ? o_lo_error : o_hi_error);
    endtask

    always @(posedge clk) begin
        query_t q;
        if (i_reset) begin
            sb.delete();
            exp_bank = 0;
        end else begin
            if (o_hi_ack || o_lo_ack) begin
                if (sb.size() == 0) begin
                    errors++;
                    $display("%0t: acknowledge arrived with no open query", $time);
                end else begin
                    check_ack(sb.pop_front());
                end
            end
            if ((i_hi_req && o_hi_rdy) || (i_lo_req && o_lo_rdy)) begin
                q.src  = !(i_hi_req && o_hi_rdy);
                q.key  = q.src ? i_lo_key : i_hi_key;
                q.bank = exp_bank;
                check_value($sformatf("o_bank_req[%0d]", exp_bank), 1, o_bank_req[exp_bank]);
                check_value($sformatf("o_bank_key[%0d]", exp_bank), q.key, o_bank_key[exp_bank]);
                sb.push_back(q);
                exp_bank = (exp_bank + 1) % NB;
            end
        end
        open_cnt = sb.size();
    end

    // ==================================================
    // Protocol assertions
    // ==================================================
    a_idle: assert property (@(posedge clk) disable iff (i_reset)
        (!i_hi_req && !i_lo_req && open_cnt == 0) |->
        !(o_hi_rdy || o_lo_rdy || o_hi_ack || o_lo_ack || o_bank_req[0] || o_bank_req[1]))
        else begin
            errors++;
            $display("%0t: router drove rdy, ack or bank req while idle", $time);
        end

    a_lo_blocked: assert property (@(posedge clk) disable iff (i_reset)
        i_hi_req |-> !o_lo_rdy)
        else begin
            errors++;
            $display("Fail %0t: o_lo_rdy expected 0 got 1", $time);
        end

    a_hi_granted: assert property (@(posedge clk) disable iff (i_reset)
        (i_hi_req && i_bank_rdy[exp_bank] && open_cnt < `DB_CTXT_DEPTH) |-> o_hi_rdy)
        else begin
            errors++;
            $display("Fail %0t: o_hi_rdy expected 1 got 0", $time);
        end

    a_lo_granted: assert property (@(posedge clk) disable iff (i_reset)
        (!i_hi_req && i_lo_req && i_bank_rdy[exp_bank] && open_cnt < `DB_CTXT_DEPTH)
        |-> o_lo_rdy)
        else begin
            errors++;
            $display("Fail %0t: o_lo_rdy expected 1 got 0", $time);
        end

    a_bank_stall: assert property (@(posedge clk) disable iff (i_reset)
        !i_bank_rdy[exp_bank] |-> !(o_hi_rdy || o_lo_rdy))
        else begin
            errors++;
            $display("%0t: rdy passed while the selected bank was not ready", $time);
        end

    a_full_stall: assert property (@(posedge clk) disable iff (i_reset)
        (open_cnt >= `DB_CTXT_DEPTH) |-> !(o_hi_rdy || o_lo_rdy))
        else begin
            errors++;
            $display("%0t: rdy passed with %0d queries open", $time, open_cnt);
        end

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Holds req and key until rdy is seen on an edge
    task automatic send_query(input bit src, input key_t key);
        logic taken;
        if (src) begin
            i_lo_req = 1'b1;
            i_lo_key = key;
        end else begin
            i_hi_req = 1'b1;
            i_hi_key = key;
        end
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = src ? o_lo_rdy : o_hi_rdy;
            @(posedge clk);
            #1;
        end
        if (src) begin
            i_lo_req = 1'b0;
        end else begin
            i_hi_req = 1'b0;
        end
    endtask

    task automatic random_stream(input bit src, input int count);
        for (int i = 0; i < count; i++) begin
            idle_cycles($urandom_range(0, 3));
            send_query(src, key_t'($urandom));
        end
    endtask

    // Cycle limit
    always @(posedge clk) begin
        cyc++;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d queries open, %0d errors",
                     cyc, open_cnt, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        void'($urandom(55));
        i_reset  = 1'b1;
        i_hi_req = 1'b0;
        i_hi_key = '0;
        i_lo_req = 1'b0;
        i_lo_key = '0;
        hold_ack = 1'b0;
        for (int b = 0; b < NB; b++) begin
            i_bank_rdy[b]   = 1'b1;
            i_bank_ack[b]   = 1'b0;
            i_bank_error[b] = 1'b0;
            i_bank_valid[b] = 1'b0;
            i_bank_value[b] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        i_reset = 1'b0;
        idle_cycles(10);

        // Same-cycle requests from both sides
        fork
            send_query(SRC_HI, 8'h11);
            send_query(SRC_LO, 8'h22);
        join
        idle_cycles(6);

        // Next bank not ready for a while
        stall_bank = exp_bank;
        i_bank_rdy[stall_bank] = 1'b0;
        fork
            send_query(SRC_LO, 8'h33);
            begin
                idle_cycles(5);
                i_bank_rdy[stall_bank] = 1'b1;
            end
        join
        wait (open_cnt == 0);
        idle_cycles(2);

        // Acks held back until the context FIFO is full
        hold_ack = 1'b1;
        fork
            for (int i = 0; i < 10; i++) begin
                send_query(i % 2, key_t'(8'hF6 + i));
            end
            begin
                wait (open_cnt == `DB_CTXT_DEPTH);
                idle_cycles(6);
                hold_ack = 1'b0;
            end
        join
        wait (open_cnt == 0);
        idle_cycles(2);

        // Random traffic from both requesters
        fork
            random_stream(SRC_HI, 20);
            random_stream(SRC_LO, 20);
        join
        wait (open_cnt == 0);
        idle_cycles(4);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_db_query_router

/* filelist.f */
+incdir+.
db_router_pkg.sv
db_query_if.sv
db_ctxt_fifo.sv
db_route_ctrl.sv
db_request_mux.sv
db_bank_steer.sv
db_query_router.sv
tb_db_query_router.sv

/* Bender.yml */
package:
  name: db_query_router

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - db_router_pkg.sv
      - db_query_if.sv
      - db_ctxt_fifo.sv
      - db_route_ctrl.sv
      - db_request_mux.sv
      - db_bank_steer.sv
      - db_query_router.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_db_query_router.sv
